// ==== design/mem_op_pkg.sv ====
package mem_op_pkg;

    // Operation as seen by the memory stage
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        // Non-memory result that passes through unchanged
        OP_ALU   = 4'd1,
        OP_LD_B  = 4'd2,
        OP_LD_BU = 4'd3,
        OP_LD_H  = 4'd4,
        OP_LD_HU = 4'd5,
        OP_LD_W  = 4'd6,
        OP_ST_B  = 4'd7,
        OP_ST_H  = 4'd8,
        OP_ST_W  = 4'd9,
        OP_LL    = 4'd10,
        OP_SC    = 4'd11
    } mem_op_e;

    // Bit n enables byte n of the word
    localparam logic [3:0] SEL_BYTE0   = 4'b0001;
    localparam logic [3:0] SEL_BYTE1   = 4'b0010;
    localparam logic [3:0] SEL_BYTE2   = 4'b0100;
    localparam logic [3:0] SEL_BYTE3   = 4'b1000;

    // Halfword lanes
    localparam logic [3:0] SEL_HALF_LO = 4'b0011;
    localparam logic [3:0] SEL_HALF_HI = 4'b1100;

    localparam logic [3:0] SEL_WORD    = 4'b1111;

endpackage

// ==== design/pipeline_pkg.sv ====
package pipeline_pkg;

    // Execute to memory stage
    typedef struct packed {
        logic [31:0]         pc;
        mem_op_pkg::mem_op_e op;
        logic [31:0]         mem_addr;
        // Store source register
        logic [31:0]         reg2;
        logic                wreg;
        logic [4:0]          waddr;
        logic [31:0]         wdata;
        logic                excp;
        logic [9:0]          excp_num;
    } ex_mem_t;

    // Memory stage to writeback
    typedef struct packed {
        logic [31:0] pc;
        logic        wreg;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic        excp;
        logic [9:0]  excp_num;
        logic [31:0] mem_addr;
        logic        is_load;
    } mem_wb_t;

    // Data cache request held until data_ok
    typedef struct packed {
        logic        ce;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] addr;
        // Store data replicated over all lanes
        logic [31:0] data;
    } cache_req_t;

    // Bypass to dispatch and execute
    typedef struct packed {
        logic        is_load;
        logic        wreg;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } mem_fwd_t;

endpackage

// ==== design/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     en_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (en_i) begin
            valid_q <= valid_i;
        end
    end

    // Bubbles leave the payload alone
    always_ff @(posedge clk_i) begin
        if (en_i && valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

    a_payload_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o |-> !$isunknown(data_o))
        else $error("stage_reg: unknown payload while valid");

endmodule

// ==== design/mem_access.sv ====
`timescale 1ns/1ps

module mem_access (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     valid_i,
    input  pipeline_pkg::ex_mem_t    data_i,
    output pipeline_pkg::cache_req_t cache_req_o,
    input  logic [31:0]              cache_rdata_i,
    input  logic                     data_ok_i,
    output logic                     stall_o,
    output logic                     valid_o,
    output pipeline_pkg::mem_wb_t    data_o,
    output pipeline_pkg::mem_fwd_t   fwd_o
);

    import mem_op_pkg::*;
    import pipeline_pkg::*;

    mem_op_e     op;
    logic [1:0]  offset;
    logic        is_load;
    logic        is_store;
    logic        is_signed;
    logic        aligned;
    logic [3:0]  sel;
    logic [31:0] st_data;
    logic        issue;
    logic        done;
    logic        ll_bit_q;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    logic [31:0] ld_data;

    assign op     = data_i.op;
    assign offset = data_i.mem_addr[1:0];

    // Decode, lane select and store data replication
    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_signed = 1'b0;
        aligned   = 1'b1;
        sel       = 4'b0000;
        st_data   = data_i.reg2;
        case (op)
            OP_LD_B, OP_LD_BU, OP_ST_B: begin
                is_load   = (op != OP_ST_B);
                is_store  = (op == OP_ST_B);
                is_signed = (op == OP_LD_B);
                st_data   = {4{data_i.reg2[7:0]}};
                case (offset)
                    2'd0: sel = SEL_BYTE0;
                    2'd1: sel = SEL_BYTE1;
                    2'd2: sel = SEL_BYTE2;
                    default: sel = SEL_BYTE3;
                endcase
            end
            OP_LD_H, OP_LD_HU, OP_ST_H: begin
                is_load   = (op != OP_ST_H);
                is_store  = (op == OP_ST_H);
                is_signed = (op == OP_LD_H);
                st_data   = {2{data_i.reg2[15:0]}};
                case (offset)
                    2'd0: sel = SEL_HALF_LO;
                    2'd2: sel = SEL_HALF_HI;
                    default: aligned = 1'b0;
                endcase
            end
            OP_LD_W, OP_LL: begin
                is_load = 1'b1;
                sel     = SEL_WORD;
                aligned = (offset == 2'd0);
            end
            OP_ST_W: begin
                is_store = 1'b1;
                sel      = SEL_WORD;
                aligned  = (offset == 2'd0);
            end
            OP_SC: begin
                // Result only known here, so it forwards like a load
                is_load  = 1'b1;
                is_store = 1'b1;
                sel      = SEL_WORD;
                aligned  = (offset == 2'd0);
            end
            default: ;
        endcase
    end

    // SC without a live reservation never reaches the cache
    assign issue = valid_i && !data_i.excp && (is_load || is_store) && aligned
                   && (op != OP_SC || ll_bit_q);
    assign done    = issue && data_ok_i;
    assign stall_o = issue && !data_ok_i;
    assign valid_o = valid_i && !stall_o;

    always_comb begin
        cache_req_o.ce   = issue;
        cache_req_o.we   = issue && is_store;
        cache_req_o.sel  = issue ? sel : 4'b0000;
        cache_req_o.addr = data_i.mem_addr;
        cache_req_o.data = st_data;
    end

    // Load alignment
    assign lane_byte = cache_rdata_i[{offset, 3'b000} +: 8];
    assign lane_half = cache_rdata_i[{offset[1], 4'b0000} +: 16];

    always_comb begin
        case (op)
            OP_LD_B, OP_LD_BU: ld_data = {{24{is_signed & lane_byte[7]}}, lane_byte};
            OP_LD_H, OP_LD_HU: ld_data = {{16{is_signed & lane_half[15]}}, lane_half};
            default:           ld_data = cache_rdata_i;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ll_bit_q <= 1'b0;
        end else if (done && op == OP_LL) begin
            ll_bit_q <= 1'b1;
        end else if (done && op == OP_SC) begin
            ll_bit_q <= 1'b0;
        end
    end

    always_comb begin
        data_o.pc       = data_i.pc;
        data_o.wreg     = data_i.wreg;
        data_o.waddr    = data_i.waddr;
        data_o.wdata    = data_i.wdata;
        data_o.excp     = data_i.excp;
        data_o.excp_num = data_i.excp_num;
        data_o.mem_addr = data_i.mem_addr;
        data_o.is_load  = is_load;
        if (data_i.excp) begin
            data_o.wreg = 1'b0;
        end else if (op == OP_SC) begin
            data_o.wreg  = 1'b1;
            data_o.wdata = {31'd0, issue};
        end else if (is_load) begin
            // misaligned loads write back zero
            data_o.wreg  = 1'b1;
            data_o.wdata = aligned ? ld_data : 32'd0;
        end
    end

    always_comb begin
        fwd_o.is_load = data_o.is_load;
        fwd_o.wreg    = valid_i && data_o.wreg;
        fwd_o.waddr   = data_o.waddr;
        fwd_o.wdata   = data_o.wdata;
    end

    // Upstream register must hold the instruction for the whole wait
    a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_o |=> $stable(cache_req_o))
        else $error("mem_access: cache request changed while stalled");

    a_sel_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cache_req_o.ce |-> cache_req_o.sel != 4'b0000)
        else $error("mem_access: cache enabled with empty byte select");

endmodule

// ==== design/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     ex_valid_i,
    input  pipeline_pkg::ex_mem_t    ex_data_i,
    output logic                     stall_o,
    output pipeline_pkg::cache_req_t cache_req_o,
    input  logic [31:0]              cache_rdata_i,
    input  logic                     data_ok_i,
    output logic                     wb_valid_o,
    output pipeline_pkg::mem_wb_t    wb_data_o,
    output pipeline_pkg::mem_fwd_t   fwd_o
);

    import pipeline_pkg::*;

    logic    mem_valid;
    ex_mem_t mem_data;
    logic    res_valid;
    mem_wb_t res_data;

    // EX/MEM holds while the memory stage waits on the cache
    stage_reg #(
        .payload_t(ex_mem_t)
    ) ex_mem_reg_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .en_i     (!stall_o),
        .valid_i  (ex_valid_i),
        .data_i   (ex_data_i),
        .valid_o  (mem_valid),
        .data_o   (mem_data)
    );

    mem_access mem_access_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .valid_i       (mem_valid),
        .data_i        (mem_data),
        .cache_req_o   (cache_req_o),
        .cache_rdata_i (cache_rdata_i),
        .data_ok_i     (data_ok_i),
        .stall_o       (stall_o),
        .valid_o       (res_valid),
        .data_o        (res_data),
        .fwd_o         (fwd_o)
    );

    // res_valid is already low during a stall, so a bubble enters
    stage_reg #(
        .payload_t(mem_wb_t)
    ) mem_wb_reg_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .en_i     (1'b1),
        .valid_i  (res_valid),
        .data_i   (res_data),
        .valid_o  (wb_valid_o),
        .data_o   (wb_data_o)
    );

endmodule

// ==== dv/cache_model.sv ====
`timescale 1ns/1ps

module cache_model #(
    parameter int SEED = 1
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  pipeline_pkg::cache_req_t req_i,
    output logic [31:0]              rdata_o,
    output logic                     data_ok_o
);

    logic [31:0] mem [0:63];
    logic [5:0]  idx;
    // Cycles left before data_ok for the current request
    logic [1:0]  wait_q;
    int          seed;

    assign idx       = req_i.addr[7:2];
    assign rdata_o   = mem[idx];
    assign data_ok_o = req_i.ce && (wait_q == 2'd0);

    initial begin
        seed = SEED;
        for (int i = 0; i < 64; i++) begin
            mem[i] <= (32'h9e3779b9 * (i + 1)) ^ (i << 24);
        end
    end

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_q <= 2'd1;
        end else if (req_i.ce) begin
            if (wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.we && req_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
                    end
                end
                // New delay of 0 to 3 cycles for the next access
                wait_q <= 2'($random(seed));
            end
        end
    end

endmodule

// ==== dv/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb;

    import mem_op_pkg::*;
    import pipeline_pkg::*;

    localparam int PERIOD    = 20;
    localparam int RST_CYC   = 8;
    localparam int NUM_INSTR = 121;
    localparam int SEED      = 32'hb4b62b70;

    logic       clk;
    logic       arst_n;
    logic       ex_valid;
    ex_mem_t    ex_data;
    logic       stall;
    cache_req_t cache_req;
    logic [31:0] cache_rdata;
    logic       data_ok;
    logic       wb_valid;
    mem_wb_t    wb_data;
    mem_fwd_t   fwd;

    // Reference state, updated in program order
    logic [31:0] shadow [0:63];
    logic        ll_ref;
    mem_wb_t     exp_wb [0:255];
    cache_req_t  exp_req [0:255];
    logic [7:0]  wr_idx;
    logic [7:0]  acc_cnt;
    logic [7:0]  rd_idx;
    logic [7:0]  mem_idx;
    logic        mem_busy;
    int          seed;
    int          errors;
    int          err_mark;
    int          tests;

    always #(PERIOD / 2) clk = ~clk;

    mem_subsys_top dut_i (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .ex_valid_i    (ex_valid),
        .ex_data_i     (ex_data),
        .stall_o       (stall),
        .cache_req_o   (cache_req),
        .cache_rdata_i (cache_rdata),
        .data_ok_i     (data_ok),
        .wb_valid_o    (wb_valid),
        .wb_data_o     (wb_data),
        .fwd_o         (fwd)
    );

    cache_model #(
        .SEED(SEED)
    ) cache_i (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .req_i     (cache_req),
        .rdata_o   (cache_rdata),
        .data_ok_o (data_ok)
    );

    always @(posedge clk) begin
        if (!arst_n) begin
            rd_idx <= 8'd0;
        end else if (wb_valid) begin
            rd_idx <= rd_idx + 8'd1;
        end
    end

    // Memory stage holds the oldest instruction not yet in writeback
    assign mem_idx  = rd_idx + {7'd0, wb_valid};
    assign mem_busy = acc_cnt > mem_idx;

    task automatic report_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        errors = errors + 1;
    endtask

    a_reset_quiet: assert property (@(negedge clk)
        !arst_n |-> !wb_valid && !stall && !cache_req.ce && !fwd.wreg)
        else report_error("outputs active during reset");

    a_wb_payload: assert property (@(negedge clk) disable iff (!arst_n)
        wb_valid |-> rd_idx < acc_cnt && wb_data == exp_wb[rd_idx])
        else report_error("writeback payload differs from expected");

    a_req_issue: assert property (@(negedge clk) disable iff (!arst_n)
        cache_req.ce == (mem_busy && exp_req[mem_idx].ce))
        else report_error("cache enable differs from expected issue");

    a_req_fields: assert property (@(negedge clk) disable iff (!arst_n)
        cache_req.ce |-> cache_req.sel == exp_req[mem_idx].sel
            && cache_req.we == exp_req[mem_idx].we
            && cache_req.addr == exp_req[mem_idx].addr
            && (!cache_req.we || cache_req.data == exp_req[mem_idx].data))
        else report_error("cache request fields differ from expected");

    a_stall_level: assert property (@(negedge clk) disable iff (!arst_n)
        stall == (mem_busy && exp_req[mem_idx].ce && !data_ok))
        else report_error("stall does not match pending access");

    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> $stable(cache_req))
        else report_error("cache request changed during stall");

    a_fwd_gate: assert property (@(negedge clk) disable iff (!arst_n)
        fwd.wreg == (mem_busy && exp_wb[mem_idx].wreg))
        else report_error("forward write enable differs from memory stage");

    a_fwd_data: assert property (@(negedge clk) disable iff (!arst_n)
        fwd.wreg && !stall |-> fwd.waddr == exp_wb[mem_idx].waddr
            && fwd.wdata == exp_wb[mem_idx].wdata
            && fwd.is_load == exp_wb[mem_idx].is_load)
        else report_error("forward bundle differs from later writeback");

    task automatic predict(input ex_mem_t ex);
        logic [1:0]  off;
        logic [5:0]  idx;
        logic [31:0] word;
        logic [31:0] lane;
        logic [31:0] ld_val;
        logic        aligned;
        logic        issue;
        mem_wb_t     wb;
        cache_req_t  req;
        off     = ex.mem_addr[1:0];
        idx     = ex.mem_addr[7:2];
        word    = shadow[idx];
        lane    = word >> (8 * off);
        aligned = 1'b1;
        req     = '0;
        case (ex.op)
            OP_LD_B:  ld_val = {{24{lane[7]}}, lane[7:0]};
            OP_LD_BU: ld_val = {24'd0, lane[7:0]};
            OP_LD_H:  ld_val = {{16{lane[15]}}, lane[15:0]};
            OP_LD_HU: ld_val = {16'd0, lane[15:0]};
            default:  ld_val = word;
        endcase
        case (ex.op)
            OP_LD_B, OP_LD_BU, OP_ST_B: begin
                req.sel  = 4'b0001 << off;
                req.data = {4{ex.reg2[7:0]}};
            end
            OP_LD_H, OP_LD_HU, OP_ST_H: begin
                req.sel  = off[1] ? 4'b1100 : 4'b0011;
                req.data = {2{ex.reg2[15:0]}};
                aligned  = !off[0];
            end
            default: begin
                req.sel  = 4'b1111;
                req.data = ex.reg2;
                aligned  = (off == 2'd0);
            end
        endcase
        wb          = '0;
        wb.pc       = ex.pc;
        wb.wreg     = ex.wreg;
        wb.waddr    = ex.waddr;
        wb.wdata    = ex.wdata;
        wb.excp     = ex.excp;
        wb.excp_num = ex.excp_num;
        wb.mem_addr = ex.mem_addr;
        wb.is_load  = ex.op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL, OP_SC};
        issue = !(ex.op inside {OP_NOP, OP_ALU}) && !ex.excp && aligned
                && (ex.op != OP_SC || ll_ref);
        req.ce   = issue;
        req.we   = issue && (ex.op inside {OP_ST_B, OP_ST_H, OP_ST_W, OP_SC});
        req.addr = ex.mem_addr;
        if (ex.excp) begin
            wb.wreg = 1'b0;
        end else if (ex.op == OP_SC) begin
            wb.wreg  = 1'b1;
            wb.wdata = {31'd0, issue};
        end else if (wb.is_load) begin
            wb.wreg  = 1'b1;
            wb.wdata = aligned ? ld_val : 32'd0;
        end
        for (int b = 0; b < 4; b++) begin
            if (req.we && req.sel[b]) begin
                shadow[idx][8*b +: 8] = req.data[8*b +: 8];
            end
        end
        if (issue && ex.op == OP_LL) begin
            ll_ref = 1'b1;
        end else if (issue && ex.op == OP_SC) begin
            ll_ref = 1'b0;
        end
        exp_wb[wr_idx]  = wb;
        exp_req[wr_idx] = req;
        wr_idx          = wr_idx + 8'd1;
    endtask

    task automatic make_instr(input mem_op_e op, input logic [31:0] addr, output ex_mem_t ex);
        ex          = '0;
        ex.pc       = $random(seed);
        ex.op       = op;
        ex.mem_addr = addr;
        ex.reg2     = $random(seed);
        ex.wreg     = 1'b1;
        ex.waddr    = 5'($random(seed));
        ex.wdata    = $random(seed);
    endtask

    // Holds the instruction until the EX/MEM register takes it
    task automatic drive_instr(input ex_mem_t ex);
        predict(ex);
        ex_valid <= 1'b1;
        ex_data  <= ex;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
        acc_cnt = acc_cnt + 8'd1;
    endtask

    task automatic issue_op(input mem_op_e op, input logic [31:0] addr);
        ex_mem_t ex;
        make_instr(op, addr, ex);
        drive_instr(ex);
    endtask

    task automatic drain();
        ex_valid <= 1'b0;
        do begin
            @(negedge clk);
        end while (rd_idx != acc_cnt);
        @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int n);
        drain();
        $display("%-16s %0d instructions, %0d errors", name, n, errors - err_mark);
        err_mark = errors;
        tests    = tests + 1;
    endtask

    task automatic alu_passthrough();
        for (int k = 0; k < 8; k++) begin
            issue_op(OP_ALU, $random(seed));
        end
        finish_test("alu_passthrough", 8);
    endtask

    task automatic load_sweep();
        mem_op_e ld_ops [0:4];
        ld_ops = '{OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W};
        for (int k = 0; k < 5; k++) begin
            for (int off = 0; off < 4; off++) begin
                issue_op(ld_ops[k], {24'd0, 6'($random(seed)), 2'(off)});
            end
        end
        finish_test("load_sweep", 20);
    endtask

    task automatic store_then_read(input mem_op_e op, input logic [31:0] addr);
        issue_op(op, addr);
        issue_op(OP_LD_W, {addr[31:2], 2'd0});
    endtask

    task automatic store_merge();
        logic [5:0] w;
        for (int round = 0; round < 2; round++) begin
            w = 6'($random(seed));
            for (int off = 0; off < 4; off++) begin
                store_then_read(OP_ST_B, {24'd0, w, 2'(off)});
            end
            store_then_read(OP_ST_H, {24'd0, w, 2'd0});
            store_then_read(OP_ST_H, {24'd0, w, 2'd2});
            store_then_read(OP_ST_W, {24'd0, w, 2'd0});
        end
        finish_test("store_merge", 28);
    endtask

    task automatic llsc_sequence();
        logic [31:0] addr;
        addr = {24'd0, 6'($random(seed)), 2'd0};
        // LL bit has never been set since reset
        issue_op(OP_SC, addr);
        issue_op(OP_LL, addr);
        issue_op(OP_SC, addr);
        issue_op(OP_SC, addr);
        issue_op(OP_LD_W, addr);
        finish_test("llsc_sequence", 5);
    endtask

    task automatic random_traffic();
        ex_mem_t     ex;
        logic [31:0] r;
        for (int k = 0; k < 60; k++) begin
            r = $random(seed);
            make_instr(mem_op_e'(r[3:0] % 4'd12), {24'd0, r[31:24]}, ex);
            if (r[6:4] == 3'd0) begin
                ex.excp     = 1'b1;
                ex.excp_num = r[19:10];
            end
            drive_instr(ex);
            if (r[9:8] == 2'd0) begin
                ex_valid <= 1'b0;
                @(posedge clk);
            end
        end
        finish_test("random_traffic", 60);
    endtask

    initial begin
        #((RST_CYC + NUM_INSTR * 6 + 40) * PERIOD);
        $display("Simulation hung: instructions did not reach writeback in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        // A valid load waits at the input during reset
        ex_valid     = 1'b1;
        ex_data      = '0;
        ex_data.op   = OP_LD_W;
        ex_data.wreg = 1'b1;
        seed     = SEED;
        errors   = 0;
        err_mark = 0;
        tests    = 0;
        wr_idx   = 8'd0;
        acc_cnt  = 8'd0;
        ll_ref   = 1'b0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = (32'h9e3779b9 * (i + 1)) ^ (i << 24);
        end
        repeat (RST_CYC) @(posedge clk);
        ex_valid <= 1'b0;
        arst_n   <= 1'b1;
        @(posedge clk);
        alu_passthrough();
        load_sweep();
        store_merge();
        llsc_sequence();
        random_traffic();
        $display("tests %0d, instructions %0d, errors %0d", tests, rd_idx, errors);
        if (errors == 0 && rd_idx == wr_idx) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_subsys.f ====
design/mem_op_pkg.sv
design/pipeline_pkg.sv
design/stage_reg.sv
design/mem_access.sv
design/mem_subsys_top.sv
dv/cache_model.sv
dv/mem_subsys_tb.sv

// ==== Makefile ====
TB_TOP  := mem_subsys_tb
OBJ_DIR := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module mem_subsys_top -f mem_subsys.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f mem_subsys.f
	./$(OBJ_DIR)/V$(TB_TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
